/* div_iter_ctrl.sv */
/*
 * divider core FSM, sequences load, iterate and hand-off
 */

`timescale 1ns/1ps

module div_iter_ctrl import int_div_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic unsign_val,
  output logic unsign_rdy,
  output logic core_val,
  input  logic core_rdy,
  input  logic sub_neg,
  input  logic cnt_zero,
  output logic acc_en,
  output logic div_en,
  output logic acc_load,
  output logic cnt_load,
  output logic sign_en
);

  div_state_e state;
  div_state_e state_next;
  logic       accept;
  logic       send;

  // core transfers on both sides
  assign accept = (state == st_idle) & unsign_val;
  assign send   = (state == st_done) & core_rdy;

  // ------------------------------------------------------------------------
  // state register
  // ------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_calc;
      // last iteration runs with the counter at zero
      st_calc: if (cnt_zero) state_next = st_done;
      st_done: if (send) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------------------------------
  // outputs decoded from state
  // ------------------------------------------------------------------------

  // handshake
  assign unsign_rdy = (state == st_idle);
  assign core_val   = (state == st_done);

  // load on accept, iterate through calc
  assign acc_en   = accept | (state == st_calc);
  assign acc_load = (state == st_idle);
  assign cnt_load = (state == st_idle);
  assign sign_en  = accept;

  // keep the difference only when it stayed non-negative
  assign div_en = (state == st_calc) & ~sub_neg;

endmodule

/* div_iter_dpath.sv */
/*
 * restoring shift-subtract datapath, one quotient bit per cycle
 */

`timescale 1ns/1ps

module div_iter_dpath import int_div_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [data_w-1:0] mag_a,
  input  logic [data_w-1:0] mag_b,
  input  logic              neg_quot,
  input  logic              neg_rem,
  input  logic              acc_en,
  input  logic              div_en,
  input  logic              acc_load,
  input  logic              cnt_load,
  input  logic              sign_en,
  output logic              sub_neg,
  output logic              cnt_zero,
  output logic [data_w-1:0] core_quot,
  output logic [data_w-1:0] core_rem,
  output logic              core_neg_quot,
  output logic              core_neg_rem
);

  logic [acc_w-1:0] acc_reg;
  logic [acc_w-1:0] div_reg;
  logic [acc_w-1:0] acc_shift;
  logic [acc_w-1:0] acc_diff;
  logic [acc_w-1:0] acc_next;
  logic [cnt_w-1:0] cnt_reg;

  // ------------------------------------------------------------------------
  // shift and trial subtract
  // ------------------------------------------------------------------------

  assign acc_shift = acc_reg << 1;
  assign acc_diff  = acc_shift - div_reg;

  // guard bit set means the divisor did not fit
  assign sub_neg = acc_diff[acc_w-1];

  always_comb begin
    if (acc_load) begin
      // dividend in the low word, remainder half cleared
      acc_next = {{(acc_w - data_w){1'b0}}, mag_a};
    end else if (div_en) begin
      // keep the difference, quotient bit one
      acc_next = {acc_diff[acc_w-1:1], 1'b1};
    end else begin
      // restore, shifted value already has quotient bit zero
      acc_next = acc_shift;
    end
  end

  // working register and divisor, payload only
  always_ff @(posedge clk) begin
    if (acc_en) begin
      acc_reg <= acc_next;
    end
    if (acc_en && acc_load) begin
      // divisor lines up with the remainder half
      div_reg <= {1'b0, mag_b, {data_w{1'b0}}};
    end
    if (sign_en) begin
      core_neg_quot <= neg_quot;
      core_neg_rem  <= neg_rem;
    end
  end

  // ------------------------------------------------------------------------
  // iteration counter
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (acc_en) begin
      cnt_reg <= cnt_load ? cnt_w'(iter_last) : cnt_reg - cnt_w'(1);
    end
  end

  assign cnt_zero = (cnt_reg == '0);

  // remainder in the upper word, quotient in the lower
  assign core_quot = acc_reg[data_w-1:0];
  assign core_rem  = acc_reg[2*data_w-1:data_w];

endmodule

/* div_req_unsign.sv */
/*
 * divider request stage, registers a request as operand magnitudes
 * plus the result signs needed later by the response stage
 */

`timescale 1ns/1ps

module div_req_unsign import int_div_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  div_fn_e           req_fn,
  input  logic [data_w-1:0] req_a,
  input  logic [data_w-1:0] req_b,
  output logic              unsign_val,
  input  logic              unsign_rdy,
  output logic [data_w-1:0] mag_a,
  output logic [data_w-1:0] mag_b,
  output logic              neg_quot,
  output logic              neg_rem
);

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic req_go;

  // operand signs only count for a signed request
  assign is_signed = (req_fn == div_fn_signed);
  assign a_neg     = is_signed & req_a[data_w-1];
  assign b_neg     = is_signed & req_b[data_w-1];

  // take a new item when empty or when the held one leaves this edge
  assign req_rdy = ~unsign_val | unsign_rdy;
  assign req_go  = req_val & req_rdy;

  // valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      unsign_val <= 1'b0;
    end else if (req_rdy) begin
      unsign_val <= req_val;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (req_go) begin
      // two's complement magnitude of a negative operand
      mag_a    <= a_neg ? (~req_a + 1'b1) : req_a;
      mag_b    <= b_neg ? (~req_b + 1'b1) : req_b;
      // quotient negative when signs differ, remainder follows a
      neg_quot <= a_neg ^ b_neg;
      neg_rem  <= a_neg;
    end
  end

endmodule

/* div_resp_fixup.sv */
/*
 * divider response stage, sign-corrects the result and holds it
 * until it is taken
 */

`timescale 1ns/1ps

module div_resp_fixup import int_div_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                core_val,
  output logic                core_rdy,
  input  logic [data_w-1:0]   core_quot,
  input  logic [data_w-1:0]   core_rem,
  input  logic                core_neg_quot,
  input  logic                core_neg_rem,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [result_w-1:0] resp_result
);

  logic [data_w-1:0] quot_fix;
  logic [data_w-1:0] rem_fix;
  logic              core_go;

  // negate where the request stage said so
  assign quot_fix = core_neg_quot ? (~core_quot + 1'b1) : core_quot;
  assign rem_fix  = core_neg_rem ? (~core_rem + 1'b1) : core_rem;

  // one entry, free when empty or draining this edge
  assign core_rdy = ~resp_val | resp_rdy;
  assign core_go  = core_val & core_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (core_rdy) begin
      resp_val <= core_val;
    end
  end

  // remainder high, quotient low
  always_ff @(posedge clk) begin
    if (core_go) begin
      resp_result <= {rem_fix, quot_fix};
    end
  end

endmodule

/* int_div_chk.sv */
/*
 * handshake checker for the divider response port
 */

`timescale 1ns/1ps

module int_div_chk import int_div_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                resp_val,
  input logic                resp_rdy,
  input logic [result_w-1:0] resp_result
);

  // no response while in reset or on the first cycle out of it
  resp_low_in_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high during or right after reset");

  // held result must not move under back-pressure
  resp_data_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result))
    else $error("resp_result changed while waiting for resp_rdy");

  // once offered, a response stays offered until taken
  resp_val_held: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else $error("resp_val dropped before the transfer");

endmodule

bind int_div_iterative int_div_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

/* int_div_iterative.sv */
/*
 * iterative 32-bit integer divider, request stage, core and
 * response stage in a three-item pipeline
 */

`timescale 1ns/1ps

module int_div_iterative import int_div_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  div_fn_e             req_fn,
  input  logic [data_w-1:0]   req_a,
  input  logic [data_w-1:0]   req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [result_w-1:0] resp_result
);

  // request stage to core
  logic              unsign_val;
  logic              unsign_rdy;
  logic [data_w-1:0] mag_a;
  logic [data_w-1:0] mag_b;
  logic              neg_quot;
  logic              neg_rem;

  // core to response stage
  logic              core_val;
  logic              core_rdy;
  logic [data_w-1:0] core_quot;
  logic [data_w-1:0] core_rem;
  logic              core_neg_quot;
  logic              core_neg_rem;

  // controller to datapath and back
  logic acc_en;
  logic div_en;
  logic acc_load;
  logic cnt_load;
  logic sign_en;
  logic sub_neg;
  logic cnt_zero;

  div_req_unsign u_req (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_fn     (req_fn),
    .req_a      (req_a),
    .req_b      (req_b),
    .unsign_val (unsign_val),
    .unsign_rdy (unsign_rdy),
    .mag_a      (mag_a),
    .mag_b      (mag_b),
    .neg_quot   (neg_quot),
    .neg_rem    (neg_rem)
  );

  div_iter_dpath u_dpath (
    .clk           (clk),
    .reset         (reset),
    .mag_a         (mag_a),
    .mag_b         (mag_b),
    .neg_quot      (neg_quot),
    .neg_rem       (neg_rem),
    .acc_en        (acc_en),
    .div_en        (div_en),
    .acc_load      (acc_load),
    .cnt_load      (cnt_load),
    .sign_en       (sign_en),
    .sub_neg       (sub_neg),
    .cnt_zero      (cnt_zero),
    .core_quot     (core_quot),
    .core_rem      (core_rem),
    .core_neg_quot (core_neg_quot),
    .core_neg_rem  (core_neg_rem)
  );

  div_iter_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .unsign_val (unsign_val),
    .unsign_rdy (unsign_rdy),
    .core_val   (core_val),
    .core_rdy   (core_rdy),
    .sub_neg    (sub_neg),
    .cnt_zero   (cnt_zero),
    .acc_en     (acc_en),
    .div_en     (div_en),
    .acc_load   (acc_load),
    .cnt_load   (cnt_load),
    .sign_en    (sign_en)
  );

  div_resp_fixup u_resp (
    .clk           (clk),
    .reset         (reset),
    .core_val      (core_val),
    .core_rdy      (core_rdy),
    .core_quot     (core_quot),
    .core_rem      (core_rem),
    .core_neg_quot (core_neg_quot),
    .core_neg_rem  (core_neg_rem),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .resp_result   (resp_result)
  );

endmodule

/* int_div_pkg.sv */
/*
 * shared definitions for the iterative integer divider
 */

package int_div_pkg;

  // ------------------------------------------------------------------------
  // widths and counts
  // ------------------------------------------------------------------------

  // one operand word
  localparam int data_w = 32;

  // response packs remainder over quotient
  localparam int result_w = 2 * data_w;

  // working register, two words plus a guard bit for the trial sign
  localparam int acc_w = 2 * data_w + 1;

  // iteration counter width, enough for data_w - 1
  localparam int cnt_w = 5;

  // counter load value, gives data_w iterations down to zero
  localparam int iter_last = data_w - 1;

  // ------------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------------

  // request function
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // core controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

endpackage

/* src.f */
int_div_pkg.sv
div_req_unsign.sv
div_iter_dpath.sv
div_iter_ctrl.sv
div_resp_fixup.sv
int_div_iterative.sv
int_div_chk.sv
tb_int_div.sv

/* tb_int_div.sv */
/*
 * testbench for the iterative divider that checks random requests under
 * random back-pressure against a reference model queue
 */

`timescale 1ns/1ps

module tb_int_div import int_div_pkg::*; ();

  localparam int num_reqs   = 400;
  localparam int max_cycles = num_reqs * 40 * 4;

  logic                clk;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  div_fn_e             req_fn;
  logic [data_w-1:0]   req_a;
  logic [data_w-1:0]   req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [result_w-1:0] resp_result;

  integer              seed;
  int                  n_issued;
  int                  n_recv;
  int                  cycle_cnt;
  logic [result_w-1:0] exp_q[$];
  logic [result_w-1:0] exp_word;
  logic [data_w-1:0]   exp_quot;
  logic [data_w-1:0]   exp_rem;
  logic                held_last;
  logic [result_w-1:0] held_result;
  div_fn_e             nxt_fn;
  logic [data_w-1:0]   nxt_a;
  logic [data_w-1:0]   nxt_b;

  int_div_iterative u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_quot(input logic [data_w-1:0] exp, input logic [data_w-1:0] got);
    if (got !== exp)
      report_failure($sformatf("error at %0d ns: quotient expected %h, got %h",
                               $time, exp, got));
  endtask

  task automatic check_rem(input logic [data_w-1:0] exp, input logic [data_w-1:0] got);
    if (got !== exp)
      report_failure($sformatf("error at %0d ns: remainder expected %h, got %h",
                               $time, exp, got));
  endtask

  // true with roughly pct percent probability
  function automatic bit roll(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // a quarter of operands come from the corner list
  function automatic logic [data_w-1:0] pick_operand();
    if (roll(25)) begin
      case ($unsigned($random(seed)) % 5)
        0:       return 32'h0000_0000;
        1:       return 32'h0000_0001;
        2:       return 32'hffff_ffff;
        3:       return 32'h8000_0000;
        default: return 32'h7fff_ffff;
      endcase
    end
    return $random(seed);
  endfunction

  // reference division on magnitudes followed by the sign fix
  task automatic model_div(input div_fn_e fn, input logic [data_w-1:0] a,
                           input logic [data_w-1:0] b,
                           output logic [data_w-1:0] q, output logic [data_w-1:0] r);
    logic              sa;
    logic              sb;
    logic [data_w-1:0] ma;
    logic [data_w-1:0] mb;
    logic [data_w-1:0] mq;
    logic [data_w-1:0] mr;
    sa = (fn == div_fn_signed) && a[data_w-1];
    sb = (fn == div_fn_signed) && b[data_w-1];
    ma = sa ? -a : a;
    mb = sb ? -b : b;
    // divide by zero gives an all ones quotient and the dividend as remainder
    if (mb == '0) begin
      mq = '1;
      mr = ma;
    end else begin
      mq = ma / mb;
      mr = ma % mb;
    end
    q = (sa ^ sb) ? -mq : mq;
    r = sa ? -mr : mr;
  endtask

  // a few directed corner cases come before the random ones
  task automatic next_request(output div_fn_e fn, output logic [data_w-1:0] a,
                              output logic [data_w-1:0] b);
    case (n_issued)
      0: begin
        fn = div_fn_signed;
        a  = 32'h8000_0000;
        b  = 32'hffff_ffff;
      end
      1: begin
        fn = div_fn_unsigned;
        a  = 32'h1234_5678;
        b  = 32'h0000_0000;
      end
      2: begin
        fn = div_fn_signed;
        a  = 32'hffff_fff9;
        b  = 32'h0000_0000;
      end
      3: begin
        fn = div_fn_signed;
        a  = 32'hffff_fff9;
        b  = 32'h0000_0002;
      end
      4: begin
        fn = div_fn_signed;
        a  = 32'h0000_0007;
        b  = 32'hffff_fffe;
      end
      5: begin
        fn = div_fn_signed;
        a  = 32'hffff_fff9;
        b  = 32'hffff_fffe;
      end
      default: begin
        fn = roll(50) ? div_fn_signed : div_fn_unsigned;
        a  = pick_operand();
        b  = pick_operand();
      end
    endcase
  endtask

  // ------------------------------------------------------------------------
  // stimulus, model and checks on the rising edge
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      if (exp_q.size() != 0)
        report_failure($sformatf("timeout with %0d requests left without a response",
                                 exp_q.size()));
      else
        report_failure("timeout: the divider stopped taking requests");
    end
    if (reset) begin
      req_val  <= 1'b0;
      resp_rdy <= 1'b0;
    end else begin
      // response held under back-pressure must not change
      if (held_last) begin
        if (!resp_val)
          report_failure("resp_val dropped before the response was taken");
        else if (resp_result !== held_result)
          report_failure($sformatf("error at %0d ns: held result changed to %h",
                                   $time, resp_result));
      end
      held_last   = resp_val && !resp_rdy;
      held_result = resp_result;
      // response transfer
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0)
          report_failure("a response arrived with no request outstanding");
        exp_word = exp_q.pop_front();
        check_quot(exp_word[data_w-1:0], resp_result[data_w-1:0]);
        check_rem(exp_word[result_w-1:data_w], resp_result[result_w-1:data_w]);
        n_recv = n_recv + 1;
      end
      // request transfer feeds the model
      if (req_val && req_rdy) begin
        model_div(req_fn, req_a, req_b, exp_quot, exp_rem);
        exp_q.push_back({exp_rem, exp_quot});
      end
      // new request only when the slot is free
      if (!req_val || req_rdy) begin
        if (n_issued < num_reqs && roll(60)) begin
          next_request(nxt_fn, nxt_a, nxt_b);
          req_fn   <= nxt_fn;
          req_a    <= nxt_a;
          req_b    <= nxt_b;
          req_val  <= 1'b1;
          n_issued = n_issued + 1;
        end else begin
          req_val <= 1'b0;
        end
      end
      resp_rdy <= roll(50);
    end
  end

  initial begin
    seed      = 32'h0516943a;
    clk       = 1'b0;
    reset     = 1'b1;
    req_val   = 1'b0;
    req_fn    = div_fn_unsigned;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b0;
    n_issued  = 0;
    n_recv    = 0;
    cycle_cnt = 0;
    held_last = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    wait (n_recv == num_reqs);
    // drain window to catch stray responses
    repeat (50) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule
